/* include/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// data path widths
`define CONV_DATA_WIDTH 16
`define CONV_ACC_WIDTH 32

// image and kernel geometry
`define CONV_IFM_SIZE 6
`define CONV_KERNEL_SIZE 3
// kernel side squared
`define CONV_TAPS 9

// filter bank
`define CONV_NUM_UNITS 4

// host port
`define CONV_ADDR_WIDTH 8

`endif

/* logic/conv_pkg.sv */
`include "conv_cfg.svh"

package conv_pkg;

	localparam int UNIT_BITS = $clog2(`CONV_NUM_UNITS);
	localparam int TAP_BITS = $clog2(`CONV_TAPS);
	localparam logic REGION_BIAS = 1'b1;

	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	// tap 0 is the top left, raster order
	typedef pixel_t [`CONV_TAPS-1:0] window_t;
	typedef pixel_t [`CONV_TAPS-1:0] coeff_set_t;

	typedef struct packed {
		logic region;
		logic [UNIT_BITS-1:0] unit;
		logic [TAP_BITS-1:0] tap;
		logic [`CONV_ADDR_WIDTH-UNIT_BITS-TAP_BITS-2:0] spare;
	} weight_addr_t;

	typedef struct packed {
		logic region;
		logic [UNIT_BITS-1:0] unit;
		logic [`CONV_ADDR_WIDTH-UNIT_BITS-2:0] spare;
	} bias_addr_t;

	// region bit on top selects which view applies
	typedef union packed {
		weight_addr_t weight;
		bias_addr_t bias;
	} host_addr_u;

endpackage

/* logic/window_generator.sv */
`include "conv_cfg.svh"

module window_generator (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input conv_pkg::pixel_t pixel_data,
	output conv_pkg::window_t window,
	output logic window_valid
);

	localparam int K = `CONV_KERNEL_SIZE;
	localparam int IFM = `CONV_IFM_SIZE;
	localparam int POS_WIDTH = $clog2(IFM);
	localparam logic [POS_WIDTH-1:0] LAST_POS = POS_WIDTH'(IFM - 1);
	localparam logic [POS_WIDTH-1:0] EDGE_POS = POS_WIDTH'(K - 1);

	////////////////////////////////////////
	// line buffers
	////////////////////////////////////////

	// oldest entry sits at the top index, one row back from the input
	conv_pkg::pixel_t [IFM-1:0] line_0;
	conv_pkg::pixel_t [IFM-1:0] line_1;
	conv_pkg::pixel_t [K-1:0] column_in;

	logic [POS_WIDTH-1:0] row;
	logic [POS_WIDTH-1:0] col;

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_0 <= {line_0[IFM-2:0], pixel_data};
			line_1 <= {line_1[IFM-2:0], line_0[IFM-1]};
		end
	end

	// index 0 is the top row of the new window column
	assign column_in = {pixel_data, line_0[IFM-1], line_1[IFM-1]};

	////////////////////////////////////////
	// window shift register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 1; c++) begin
					window[r*K+c] <= window[r*K+c+1];
				end
				window[r*K+K-1] <= column_in[r];
			end
		end
	end

	////////////////////////////////////////
	// position counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			row <= '0;
			col <= '0;
			window_valid <= 1'b0;
		end else begin
			// full window once two rows and two columns are behind us
			window_valid <= pixel_valid && (row >= EDGE_POS) && (col >= EDGE_POS);
			if (pixel_valid) begin
				if (col == LAST_POS) begin
					col <= '0;
					// wrap into the next frame
					if (row == LAST_POS) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

/* logic/coefficient_store.sv */
`include "conv_cfg.svh"

module coefficient_store (
	input logic clk,
	input logic reset,
	input logic host_write,
	input conv_pkg::host_addr_u host_address,
	input conv_pkg::pixel_t host_data,
	output conv_pkg::coeff_set_t weights [`CONV_NUM_UNITS],
	output conv_pkg::pixel_t bias [`CONV_NUM_UNITS]
);

	localparam logic [conv_pkg::TAP_BITS-1:0] TAP_LIMIT = conv_pkg::TAP_BITS'(`CONV_TAPS);

	logic weight_write;
	logic bias_write;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	always_comb begin
		bias_write = host_write && (host_address.bias.region == conv_pkg::REGION_BIAS);
		// taps past the kernel are dropped
		weight_write = host_write
			&& (host_address.weight.region != conv_pkg::REGION_BIAS)
			&& (host_address.weight.tap < TAP_LIMIT);
	end

	////////////////////////////////////////
	// coefficient registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int u = 0; u < `CONV_NUM_UNITS; u++) begin
				weights[u] <= '0;
				bias[u] <= '0;
			end
		end else begin
			if (weight_write) begin
				weights[host_address.weight.unit][host_address.weight.tap] <= host_data;
			end
			if (bias_write) begin
				bias[host_address.bias.unit] <= host_data;
			end
		end
	end

endmodule

/* logic/filter_unit.sv */
`include "conv_cfg.svh"

module filter_unit (
	input logic clk,
	input logic reset,
	input conv_pkg::window_t window,
	input logic window_valid,
	input conv_pkg::coeff_set_t weights,
	input conv_pkg::pixel_t bias,
	output conv_pkg::acc_t result,
	output logic result_valid
);

	conv_pkg::acc_t product_sum;
	conv_pkg::acc_t sum;
	conv_pkg::acc_t biased;
	logic sum_valid;

	////////////////////////////////////////
	// stage one, multiply-add
	////////////////////////////////////////

	always_comb begin
		product_sum = '0;
		for (int t = 0; t < `CONV_TAPS; t++) begin
			product_sum = product_sum
				+ conv_pkg::acc_t'(window[t]) * conv_pkg::acc_t'(weights[t]);
		end
	end

	always_ff @(posedge clk) begin
		if (window_valid) begin
			sum <= product_sum;
		end
	end

	////////////////////////////////////////
	// stage two, bias and relu
	////////////////////////////////////////

	assign biased = sum + conv_pkg::acc_t'(bias);

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			// negative results clamp to zero
			if (biased[`CONV_ACC_WIDTH-1]) begin
				result <= '0;
			end else begin
				result <= biased;
			end
		end
	end

	// valid pipe alongside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			sum_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			sum_valid <= window_valid;
			result_valid <= sum_valid;
		end
	end

endmodule

/* logic/conv_layer_top.sv */
`include "conv_cfg.svh"

module conv_layer_top (
	input logic clk,
	input logic reset,
	input logic host_write,
	input logic [`CONV_ADDR_WIDTH-1:0] host_address,
	input conv_pkg::pixel_t host_data,
	input logic pixel_valid,
	input conv_pkg::pixel_t pixel_data,
	output logic out_valid,
	output conv_pkg::acc_t out_data [`CONV_NUM_UNITS]
);

	conv_pkg::window_t window;
	logic window_valid;
	conv_pkg::coeff_set_t weights [`CONV_NUM_UNITS];
	conv_pkg::pixel_t bias [`CONV_NUM_UNITS];
	logic unit_valid [`CONV_NUM_UNITS];

	window_generator u_window (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_data(pixel_data),
		.window(window),
		.window_valid(window_valid)
	);

	coefficient_store u_coeff (
		.clk(clk),
		.reset(reset),
		.host_write(host_write),
		.host_address(conv_pkg::host_addr_u'(host_address)),
		.host_data(host_data),
		.weights(weights),
		.bias(bias)
	);

	////////////////////////////////////////
	// filter bank
	////////////////////////////////////////

	// every unit sees the same window
	for (genvar u = 0; u < `CONV_NUM_UNITS; u++) begin : g_unit
		filter_unit u_filter (
			.clk(clk),
			.reset(reset),
			.window(window),
			.window_valid(window_valid),
			.weights(weights[u]),
			.bias(bias[u]),
			.result(out_data[u]),
			.result_valid(unit_valid[u])
		);
	end

	// units run in lockstep
	assign out_valid = unit_valid[0];

endmodule

/* sim/conv_layer_props.sv */
`include "conv_cfg.svh"

module conv_layer_props (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic out_valid,
	input conv_pkg::acc_t out_data [`CONV_NUM_UNITS]
);

	////////////////////////////////////////
	// output checks
	////////////////////////////////////////

	// pipeline is empty right after reset
	a_quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// relu leaves no negative result
	for (genvar u = 0; u < `CONV_NUM_UNITS; u++) begin : g_sign
		a_not_negative: assert property (@(posedge clk) disable iff (reset)
			out_valid |-> !out_data[u][`CONV_ACC_WIDTH-1])
			else $error("negative result on unit %0d", u);
	end

	// each output traces back to a sampled pixel
	a_pixel_behind: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(pixel_valid, 3))
		else $error("out_valid without a pixel three cycles before");

endmodule

bind conv_layer_top conv_layer_props u_props (
	.clk(clk),
	.reset(reset),
	.pixel_valid(pixel_valid),
	.out_valid(out_valid),
	.out_data(out_data)
);

/* sim/conv_layer_tb.sv */
`include "conv_cfg.svh"

module conv_layer_tb;

	localparam int PERIOD = 10;
	localparam int IFM = `CONV_IFM_SIZE;
	localparam int K = `CONV_KERNEL_SIZE;
	localparam int TAPS = `CONV_TAPS;
	localparam int UNITS = `CONV_NUM_UNITS;
	localparam int PIXELS = IFM * IFM;
	localparam int OUT_SIDE = IFM - K + 1;
	localparam int LATENCY = 3;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 20;
	localparam int NUM_FRAMES = 6;
	localparam int MAX_GAP = 3;
	// three coefficient loads of eleven writes per unit
	localparam int LOAD_CYCLES = 3 * (UNITS * (TAPS + 2) + 1);
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + LOAD_CYCLES
		+ NUM_FRAMES * (PIXELS * (MAX_GAP + 1) + 10));

	logic clk = 1'b0;
	logic reset;
	logic host_write;
	logic [`CONV_ADDR_WIDTH-1:0] host_address;
	conv_pkg::pixel_t host_data;
	logic pixel_valid;
	conv_pkg::pixel_t pixel_data;
	logic out_valid;
	conv_pkg::acc_t out_data [UNITS];

	integer seed = 2199;
	string test_name = "reset";
	int cycle = 0;
	int mon_row = 0;
	int mon_col = 0;

	// testbench copy of image and coefficients
	int img [PIXELS];
	int weight_model [UNITS][TAPS];
	int bias_model [UNITS];
	int exp_values [$];
	int exp_cycles [$];

	conv_layer_top u_dut (
		.clk(clk),
		.reset(reset),
		.host_write(host_write),
		.host_address(host_address),
		.host_data(host_data),
		.pixel_valid(pixel_valid),
		.pixel_data(pixel_data),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check(input string what, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			fail_run("DUT output does not match the model");
		end
	endtask

	function automatic int random_word();
		int raw;
		raw = $random(seed);
		return int'(conv_pkg::pixel_t'(raw));
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// valid 3x3 convolution followed by bias and relu in raster order
	function automatic void fill_expected();
		int acc;
		for (int r = 0; r < OUT_SIDE; r++) begin
			for (int c = 0; c < OUT_SIDE; c++) begin
				for (int u = 0; u < UNITS; u++) begin
					acc = bias_model[u];
					for (int i = 0; i < K; i++) begin
						for (int j = 0; j < K; j++) begin
							acc += img[(r + i) * IFM + c + j] * weight_model[u][i * K + j];
						end
					end
					if (acc < 0) begin
						acc = 0;
					end
					exp_values.push_back(acc);
				end
			end
		end
	endfunction

	function automatic void make_image(input bit ramp);
		for (int p = 0; p < PIXELS; p++) begin
			img[p] = ramp ? p : random_word();
		end
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic write_word(input conv_pkg::host_addr_u address, input int data);
		@(posedge clk);
		host_write <= 1'b1;
		host_address <= address;
		host_data <= conv_pkg::pixel_t'(data);
	endtask

	task automatic load_coefficients(input bit all_ones);
		conv_pkg::host_addr_u addr;
		for (int u = 0; u < UNITS; u++) begin
			addr = '0;
			addr.weight.unit = u[conv_pkg::UNIT_BITS-1:0];
			for (int t = 0; t < TAPS; t++) begin
				weight_model[u][t] = all_ones ? 1 : random_word();
				addr.weight.tap = t[conv_pkg::TAP_BITS-1:0];
				write_word(addr, weight_model[u][t]);
			end
			// tap past the kernel is dropped by the DUT
			addr.weight.tap = conv_pkg::TAP_BITS'(12);
			write_word(addr, random_word());
			bias_model[u] = all_ones ? 0 : random_word();
			addr = '0;
			addr.bias.region = conv_pkg::REGION_BIAS;
			addr.bias.unit = u[conv_pkg::UNIT_BITS-1:0];
			write_word(addr, bias_model[u]);
		end
		@(posedge clk);
		host_write <= 1'b0;
	endtask

	// leaves pixel_valid high so frames can run back to back
	task automatic send_frame(input int max_gap);
		int gap;
		for (int p = 0; p < PIXELS; p++) begin
			gap = 0;
			if (max_gap > 0) begin
				gap = $unsigned($random(seed)) % (max_gap + 1);
			end
			repeat (gap) begin
				@(posedge clk);
				pixel_valid <= 1'b0;
			end
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel_data <= conv_pkg::pixel_t'(img[p]);
		end
	endtask

	// last result is due a fixed latency after the last pixel
	task automatic drain();
		@(posedge clk);
		pixel_valid <= 1'b0;
		repeat (LATENCY + 1) @(posedge clk);
		if (exp_values.size() != 0 || exp_cycles.size() != 0) begin
			fail_run("results were still expected after the last pixel");
		end
	endtask

	////////////////////////////////////////
	// monitor and comparison
	////////////////////////////////////////

	// pixel position tracker that says when each output is due
	always @(posedge clk) begin
		if (!reset && pixel_valid) begin
			if (mon_row >= K - 1 && mon_col >= K - 1) begin
				exp_cycles.push_back(cycle + LATENCY);
			end
			if (mon_col == IFM - 1) begin
				mon_col = 0;
				mon_row = (mon_row == IFM - 1) ? 0 : mon_row + 1;
			end else begin
				mon_col = mon_col + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && out_valid === 1'b1) begin
			if (exp_values.size() < UNITS || exp_cycles.size() == 0) begin
				fail_run("out_valid came while no result was expected");
			end else begin
				check("latency", exp_cycles.pop_front(), cycle);
				for (int u = 0; u < UNITS; u++) begin
					check($sformatf("unit %0d", u), exp_values.pop_front(), out_data[u]);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		fail_run("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		reset = 1'b1;
		host_write = 1'b0;
		host_address = '0;
		host_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		test_name = "idle";
		repeat (IDLE_CYCLES) @(posedge clk);

		test_name = "ramp";
		load_coefficients(1'b1);
		make_image(1'b1);
		fill_expected();
		send_frame(0);
		drain();

		test_name = "random";
		load_coefficients(1'b0);
		make_image(1'b0);
		fill_expected();
		send_frame(0);
		drain();

		test_name = "gaps";
		make_image(1'b0);
		fill_expected();
		send_frame(MAX_GAP);
		drain();

		test_name = "frames";
		make_image(1'b0);
		fill_expected();
		send_frame(0);
		make_image(1'b0);
		fill_expected();
		send_frame(0);
		drain();
		load_coefficients(1'b0);
		make_image(1'b0);
		fill_expected();
		send_frame(0);
		drain();

		$display("Everything OK");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
logic/conv_pkg.sv
logic/window_generator.sv
logic/coefficient_store.sv
logic/filter_unit.sv
logic/conv_layer_top.sv
sim/conv_layer_props.sv
sim/conv_layer_tb.sv
